// ==== project.f ====
+incdir+source
source/avr_pkg.sv
source/instr_decoder.sv
source/alu.sv
source/register_file.sv
source/core_sequencer.sv
source/avr_core.sv
tests/avr_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the avr_core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    -f project.f --top-module avr_core_tb -o avr_core_sim
./obj_dir/avr_core_sim

// ==== source/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "avr_cfg.svh"

module alu
(
    input  wire avr_pkg::alu_op_e       op_i,
    input  wire logic [`AVR_DATA_W-1:0] d_i,
    input  wire logic [`AVR_DATA_W-1:0] r_i,
    input  wire logic [7:0]             sreg_i,
    output logic [`AVR_DATA_W-1:0]      result_o,
    output logic [7:0]                  sreg_o
);
    import avr_pkg::*;

    localparam int MSB = `AVR_DATA_W - 1;

    logic               cin;
    logic [MSB+1:0]     sum;
    logic [MSB+1:0]     diff;
    logic               add_h;
    logic               add_v;
    logic               sub_h;
    logic               sub_v;
    logic               zero;
    logic               neg;
    logic               h;
    logic               v;
    logic               z;
    logic               c;
    logic               keep;

    // ------------------------------
    // Adder and subtractor
    // ------------------------------
    assign cin  = (op_i == ALU_ADC || op_i == ALU_SBC) && sreg_i[0];
    assign sum  = d_i + r_i + cin;
    assign diff = d_i - r_i - cin;  // Bit 8 is the borrow

    assign add_h = (d_i[3] & r_i[3]) | (r_i[3] & !sum[3]) | (!sum[3] & d_i[3]);
    assign add_v = (d_i[MSB] & r_i[MSB] & !sum[MSB]) | (!d_i[MSB] & !r_i[MSB] & sum[MSB]);
    assign sub_h = (!d_i[3] & r_i[3]) | (r_i[3] & diff[3]) | (diff[3] & !d_i[3]);
    assign sub_v = (d_i[MSB] & !r_i[MSB] & !diff[MSB]) | (!d_i[MSB] & r_i[MSB] & diff[MSB]);

    always_comb begin
        case (op_i)
            ALU_ADD, ALU_ADC: result_o = sum[MSB:0];
            ALU_SUB, ALU_SBC: result_o = diff[MSB:0];
            ALU_AND:  result_o = d_i & r_i;
            ALU_EOR:  result_o = d_i ^ r_i;
            ALU_OR:   result_o = d_i | r_i;
            ALU_COM:  result_o = ~d_i;
            ALU_NEG:  result_o = '0 - d_i;
            ALU_SWAP: result_o = {d_i[3:0], d_i[7:4]};
            ALU_INC:  result_o = d_i + 1'b1;
            ALU_DEC:  result_o = d_i - 1'b1;
            ALU_ASR:  result_o = {d_i[MSB], d_i[MSB:1]};
            ALU_LSR:  result_o = {1'b0, d_i[MSB:1]};
            ALU_ROR:  result_o = {sreg_i[0], d_i[MSB:1]};
            default:  result_o = r_i;   // LDI, MOV
        endcase
    end

    // ------------------------------
    // Status flags
    // ------------------------------
    assign zero = (result_o == '0);
    assign neg  = result_o[MSB];

    always_comb begin
        h    = sreg_i[5];
        v    = sreg_i[3];
        z    = zero;
        c    = sreg_i[0];
        keep = 1'b0;
        case (op_i)
            ALU_ADD, ALU_ADC: begin
                h = add_h;
                v = add_v;
                c = sum[MSB+1];
            end
            ALU_SUB, ALU_SBC: begin
                h = sub_h;
                v = sub_v;
                c = diff[MSB+1];
                if (op_i == ALU_SBC)
                    z = zero && sreg_i[1];  // Z chains across bytes
            end
            ALU_AND, ALU_EOR, ALU_OR: v = 1'b0;
            ALU_COM: begin
                v = 1'b0;
                c = 1'b1;
            end
            ALU_NEG: begin
                h = result_o[3] | d_i[3];
                v = (result_o == 8'h80);
                c = !zero;
            end
            ALU_INC: v = (result_o == 8'h80);
            ALU_DEC: v = (result_o == 8'h7F);
            ALU_ASR, ALU_LSR, ALU_ROR: begin
                c = d_i[0];             // Bit shifted out
                v = neg ^ d_i[0];
            end
            default: keep = 1'b1;       // SWAP and pass leave flags alone
        endcase
    end

    // I and T never change here
    assign sreg_o = keep ? sreg_i : {sreg_i[7:6], h, neg ^ v, v, neg, z, c};

endmodule

`default_nettype wire

// ==== source/avr_cfg.svh ====
`ifndef AVR_CFG_SVH
`define AVR_CFG_SVH

// Datapath
`define AVR_DATA_W      8
`define AVR_NUM_REGS    32

// X pointer lives in r27:r26
`define AVR_PTR_X_LO    26

// Program and data address widths
`define AVR_PC_W        16
`define AVR_ADDR_W      16

`endif

// ==== source/avr_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "avr_cfg.svh"

module avr_core
(
    input  wire logic                   clock,
    input  wire logic                   reset_n,
    input  wire logic [15:0]            ir_i,       // Word at pc_o
    input  wire logic [`AVR_DATA_W-1:0] data_i,
    output logic [`AVR_PC_W-1:0]        pc_o,
    output logic [`AVR_ADDR_W-1:0]      address_o,
    output logic [`AVR_DATA_W-1:0]      data_o,
    output logic                        we_o,
    output logic                        read_o
);
    import avr_pkg::*;

    ctrl_t                      ctrl;
    reg_wr_t                    reg_wr;
    ptr_wr_t                    ptr_wr;
    logic [`AVR_DATA_W-1:0]     rd_data;
    logic [`AVR_DATA_W-1:0]     rr_data;
    logic [`AVR_DATA_W-1:0]     alu_rr;
    logic [`AVR_DATA_W-1:0]     alu_result;
    logic [`AVR_ADDR_W-1:0]     x_value;
    logic [7:0]                 sreg;
    logic [7:0]                 alu_sreg;

    instr_decoder instr_decoder_inst (
        .ir_i   (ir_i),
        .ctrl_o (ctrl)
    );

    register_file register_file_inst (
        .clock     (clock),
        .reset_n   (reset_n),
        .rd_id_i   (ctrl.rd_id),
        .rr_id_i   (ctrl.rr_id),
        .reg_wr_i  (reg_wr),
        .ptr_wr_i  (ptr_wr),
        .rd_data_o (rd_data),
        .rr_data_o (rr_data),
        .x_o       (x_value)
    );

    alu alu_inst (
        .op_i     (ctrl.alu_op),
        .d_i      (rd_data),
        .r_i      (alu_rr),
        .sreg_i   (sreg),
        .result_o (alu_result),
        .sreg_o   (alu_sreg)
    );

    core_sequencer core_sequencer_inst (
        .clock        (clock),
        .reset_n      (reset_n),
        .ctrl_i       (ctrl),
        .rd_data_i    (rd_data),
        .rr_data_i    (rr_data),
        .x_i          (x_value),
        .alu_result_i (alu_result),
        .alu_sreg_i   (alu_sreg),
        .data_i       (data_i),
        .sreg_o       (sreg),
        .alu_rr_o     (alu_rr),
        .reg_wr_o     (reg_wr),
        .ptr_wr_o     (ptr_wr),
        .pc_o         (pc_o),
        .address_o    (address_o),
        .data_o       (data_o),
        .we_o         (we_o),
        .read_o       (read_o)
    );

endmodule

`default_nettype wire

// ==== source/avr_pkg.sv ====
`default_nettype none

`include "avr_cfg.svh"

package avr_pkg;

    localparam int REG_ID_W = $clog2(`AVR_NUM_REGS);

    // ------------------------------
    // ALU and memory encodings
    // ------------------------------
    typedef enum logic [4:0] {
        ALU_PASS = 5'd0,    // LDI, MOV, load data
        ALU_ADD  = 5'd1,
        ALU_ADC  = 5'd2,
        ALU_SUB  = 5'd3,    // Also CP, CPI, SUBI
        ALU_SBC  = 5'd4,    // Also CPC, SBCI
        ALU_AND  = 5'd5,
        ALU_EOR  = 5'd6,
        ALU_OR   = 5'd7,
        ALU_COM  = 5'd8,
        ALU_NEG  = 5'd9,
        ALU_SWAP = 5'd10,
        ALU_INC  = 5'd11,
        ALU_DEC  = 5'd12,
        ALU_ASR  = 5'd13,
        ALU_LSR  = 5'd14,
        ALU_ROR  = 5'd15
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        PTR_PLAIN    = 2'd0,
        PTR_POST_INC = 2'd1,
        PTR_PRE_DEC  = 2'd2
    } ptr_mode_e;

    // ------------------------------
    // Instruction word layouts
    // ------------------------------
    typedef struct packed {
        logic [5:0] opcode;
        logic       r4;         // Rr bit 4, also the ST select
        logic [4:0] rd;
        logic [3:0] rr_lo;
    } rr_fmt_t;

    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] k_hi;
        logic [3:0] rd;         // r16..r31
        logic [3:0] k_lo;
    } imm_fmt_t;

    typedef union packed {
        rr_fmt_t  rr;
        imm_fmt_t imm;
    } instr_u;

    // Decoded control for one instruction
    typedef struct packed {
        alu_op_e                alu_op;
        logic [REG_ID_W-1:0]    rd_id;
        logic [REG_ID_W-1:0]    rr_id;
        logic                   use_imm;
        logic [`AVR_DATA_W-1:0] imm;
        logic                   reg_write;
        logic                   sreg_write;
        mem_op_e                mem_op;
        ptr_mode_e              ptr_mode;
        logic                   is_jump;
        logic                   is_branch;
        logic [2:0]             br_bit;
        logic                   br_set;
        logic [`AVR_PC_W-1:0]   offset;     // Sign-extended
    } ctrl_t;

    typedef struct packed {
        logic                   en;
        logic [REG_ID_W-1:0]    id;
        logic [`AVR_DATA_W-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic                   en;
        logic [`AVR_ADDR_W-1:0] value;
    } ptr_wr_t;

endpackage

`default_nettype wire

// ==== source/core_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "avr_cfg.svh"

module core_sequencer
(
    input  wire logic                   clock,
    input  wire logic                   reset_n,
    input  wire avr_pkg::ctrl_t         ctrl_i,
    input  wire logic [`AVR_DATA_W-1:0] rd_data_i,
    input  wire logic [`AVR_DATA_W-1:0] rr_data_i,
    input  wire logic [`AVR_ADDR_W-1:0] x_i,
    input  wire logic [`AVR_DATA_W-1:0] alu_result_i,
    input  wire logic [7:0]             alu_sreg_i,
    input  wire logic [`AVR_DATA_W-1:0] data_i,
    output logic [7:0]                  sreg_o,
    output logic [`AVR_DATA_W-1:0]      alu_rr_o,
    output avr_pkg::reg_wr_t            reg_wr_o,
    output avr_pkg::ptr_wr_t            ptr_wr_o,
    output logic [`AVR_PC_W-1:0]        pc_o,
    output logic [`AVR_ADDR_W-1:0]      address_o,
    output logic [`AVR_DATA_W-1:0]      data_o,
    output logic                        we_o,
    output logic                        read_o
);
    import avr_pkg::*;

    logic                       load_phase;     // Second cycle of LD
    logic [REG_ID_W-1:0]        load_rd;
    logic                       br_taken;
    logic                       mem_access;
    logic                       load_start;
    logic [`AVR_ADDR_W-1:0]     x_dec;
    logic [`AVR_PC_W-1:0]       pc_next;

    // ------------------------------
    // Next pc and operand select
    // ------------------------------
    assign br_taken = ctrl_i.is_branch && (sreg_o[ctrl_i.br_bit] == ctrl_i.br_set);
    assign pc_next  = pc_o + 1'b1 + ((ctrl_i.is_jump || br_taken) ? ctrl_i.offset : '0);
    assign alu_rr_o = ctrl_i.use_imm ? ctrl_i.imm : rr_data_i;

    // LD word is decoded again in its second cycle, so mask it there
    assign mem_access = !load_phase && ctrl_i.mem_op != MEM_NONE;
    assign load_start = mem_access && ctrl_i.mem_op == MEM_LOAD;
    assign x_dec      = x_i - 1'b1;

    always_comb begin
        ptr_wr_o.en    = mem_access && ctrl_i.ptr_mode != PTR_PLAIN;
        ptr_wr_o.value = (ctrl_i.ptr_mode == PTR_PRE_DEC) ? x_dec : x_i + 1'b1;
        // Load data bypasses the ALU
        reg_wr_o.en    = load_phase || ctrl_i.reg_write;
        reg_wr_o.id    = load_phase ? load_rd : ctrl_i.rd_id;
        reg_wr_o.data  = load_phase ? data_i : alu_result_i;
    end

    // ------------------------------
    // Control state
    // ------------------------------
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            pc_o       <= '0;
            load_phase <= 1'b0;
            sreg_o     <= '0;
            we_o       <= 1'b0;
            read_o     <= 1'b0;
        end else begin
            we_o       <= mem_access && ctrl_i.mem_op == MEM_STORE;
            read_o     <= load_start;
            load_phase <= load_start;
            if (!load_start)
                pc_o <= pc_next;                // LD holds pc one extra cycle
            if (!load_phase && ctrl_i.sreg_write)
                sreg_o <= alu_sreg_i;
        end
    end

    // Bus payload
    always_ff @(posedge clock) begin
        if (mem_access) begin
            address_o <= (ctrl_i.ptr_mode == PTR_PRE_DEC) ? x_dec : x_i;
            data_o    <= rd_data_i;
            load_rd   <= ctrl_i.rd_id;
        end
    end

    no_read_write: assert property (@(posedge clock) disable iff (!reset_n)
        !(we_o && read_o));

    // Held pc must show the same LD word while the read is out
    read_on_entry: assert property (@(posedge clock) disable iff (!reset_n)
        read_o |-> (ctrl_i.mem_op == MEM_LOAD && ctrl_i.rd_id == load_rd));

endmodule

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "avr_cfg.svh"

module instr_decoder
(
    input  wire avr_pkg::instr_u ir_i,
    output avr_pkg::ctrl_t       ctrl_o
);
    import avr_pkg::*;

    always_comb begin
        ctrl_o = '0;    // Unknown words fall through as NOP
        casez (ir_i)
            // LDI Rd, K
            16'b1110_????_????_????: begin
                ctrl_o.rd_id     = {1'b1, ir_i.imm.rd};
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.imm       = {ir_i.imm.k_hi, ir_i.imm.k_lo};
                ctrl_o.reg_write = 1'b1;
            end
            // MOV Rd, Rr
            16'b0010_11??_????_????: begin
                ctrl_o.rd_id     = ir_i.rr.rd;
                ctrl_o.rr_id     = {ir_i.rr.r4, ir_i.rr.rr_lo};
                ctrl_o.reg_write = 1'b1;
            end
            // ------------------------------
            // Two-register ALU group
            // ------------------------------
            16'b0000_01??_????_????,
            16'b0000_1???_????_????,
            16'b0001_01??_????_????,
            16'b0001_1???_????_????,
            16'b0010_0???_????_????,
            16'b0010_10??_????_????: begin
                ctrl_o.rd_id      = ir_i.rr.rd;
                ctrl_o.rr_id      = {ir_i.rr.r4, ir_i.rr.rr_lo};
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.sreg_write = 1'b1;
                case (ir_i.rr.opcode)
                    6'b000001: begin    // CPC
                        ctrl_o.alu_op    = ALU_SBC;
                        ctrl_o.reg_write = 1'b0;
                    end
                    6'b000101: begin    // CP
                        ctrl_o.alu_op    = ALU_SUB;
                        ctrl_o.reg_write = 1'b0;
                    end
                    6'b000010: ctrl_o.alu_op = ALU_SBC;
                    6'b000011: ctrl_o.alu_op = ALU_ADD;
                    6'b000110: ctrl_o.alu_op = ALU_SUB;
                    6'b000111: ctrl_o.alu_op = ALU_ADC;
                    6'b001000: ctrl_o.alu_op = ALU_AND;
                    6'b001001: ctrl_o.alu_op = ALU_EOR;
                    default:   ctrl_o.alu_op = ALU_OR;
                endcase
            end
            // Immediate group on r16..r31
            16'b0011_????_????_????,
            16'b01??_????_????_????: begin
                ctrl_o.rd_id      = {1'b1, ir_i.imm.rd};
                ctrl_o.use_imm    = 1'b1;
                ctrl_o.imm        = {ir_i.imm.k_hi, ir_i.imm.k_lo};
                ctrl_o.reg_write  = (ir_i.imm.opcode != 4'h3);     // CPI only compares
                ctrl_o.sreg_write = 1'b1;
                case (ir_i.imm.opcode)
                    4'h4:    ctrl_o.alu_op = ALU_SBC;   // SBCI
                    4'h6:    ctrl_o.alu_op = ALU_OR;    // ORI
                    4'h7:    ctrl_o.alu_op = ALU_AND;   // ANDI
                    default: ctrl_o.alu_op = ALU_SUB;   // CPI, SUBI
                endcase
            end
            // ------------------------------
            // One-operand group
            // ------------------------------
            16'b1001_010?_????_0???,
            16'b1001_010?_????_1010: begin
                ctrl_o.rd_id      = ir_i.rr.rd;
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.sreg_write = 1'b1;
                case (ir_i.rr.rr_lo)
                    4'h0: ctrl_o.alu_op = ALU_COM;
                    4'h1: ctrl_o.alu_op = ALU_NEG;
                    4'h2: ctrl_o.alu_op = ALU_SWAP;
                    4'h3: ctrl_o.alu_op = ALU_INC;
                    4'h5: ctrl_o.alu_op = ALU_ASR;
                    4'h6: ctrl_o.alu_op = ALU_LSR;
                    4'h7: ctrl_o.alu_op = ALU_ROR;
                    4'hA: ctrl_o.alu_op = ALU_DEC;
                    default: begin
                        ctrl_o.reg_write  = 1'b0;   // Reserved slot
                        ctrl_o.sreg_write = 1'b0;
                    end
                endcase
            end
            // LD / ST through X
            16'b1001_00??_????_11??: begin
                ctrl_o.rd_id  = ir_i.rr.rd;
                ctrl_o.mem_op = ir_i.rr.r4 ? MEM_STORE : MEM_LOAD;
                case (ir_i.rr.rr_lo[1:0])
                    2'b00:   ctrl_o.ptr_mode = PTR_PLAIN;
                    2'b01:   ctrl_o.ptr_mode = PTR_POST_INC;
                    2'b10:   ctrl_o.ptr_mode = PTR_PRE_DEC;
                    default: ctrl_o.mem_op   = MEM_NONE;    // PUSH/POP slot
                endcase
            end
            // RJMP k
            16'b1100_????_????_????: begin
                ctrl_o.is_jump = 1'b1;
                ctrl_o.offset  = {{(`AVR_PC_W - 12){ir_i[11]}}, ir_i[11:0]};
            end
            // BRBS / BRBC s, k
            16'b1111_0???_????_????: begin
                ctrl_o.is_branch = 1'b1;
                ctrl_o.br_bit    = ir_i[2:0];
                ctrl_o.br_set    = !ir_i[10];
                ctrl_o.offset    = {{(`AVR_PC_W - 7){ir_i[9]}}, ir_i[9:3]};
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "avr_cfg.svh"

module register_file
(
    input  wire logic                            clock,
    input  wire logic                            reset_n,
    input  wire logic [avr_pkg::REG_ID_W-1:0]    rd_id_i,
    input  wire logic [avr_pkg::REG_ID_W-1:0]    rr_id_i,
    input  wire avr_pkg::reg_wr_t                reg_wr_i,
    input  wire avr_pkg::ptr_wr_t                ptr_wr_i,
    output logic [`AVR_DATA_W-1:0]               rd_data_o,
    output logic [`AVR_DATA_W-1:0]               rr_data_o,
    output logic [`AVR_ADDR_W-1:0]               x_o
);

    logic [`AVR_DATA_W-1:0] regs [`AVR_NUM_REGS];

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            for (int i = 0; i < `AVR_NUM_REGS; i++)
                regs[i] <= '0;
        end else begin
            if (reg_wr_i.en)
                regs[reg_wr_i.id] <= reg_wr_i.data;
            // X moves as one 16-bit value
            if (ptr_wr_i.en) begin
                regs[`AVR_PTR_X_LO]     <= ptr_wr_i.value[`AVR_DATA_W-1:0];
                regs[`AVR_PTR_X_LO + 1] <= ptr_wr_i.value[`AVR_ADDR_W-1:`AVR_DATA_W];
            end
        end
    end

    assign rd_data_o = regs[rd_id_i];
    assign rr_data_o = regs[rr_id_i];
    assign x_o       = {regs[`AVR_PTR_X_LO + 1], regs[`AVR_PTR_X_LO]};

    // Sequencer must never aim both ports at X in one cycle
    x_port_conflict: assert property (@(posedge clock) disable iff (!reset_n)
        !(reg_wr_i.en && ptr_wr_i.en &&
          (reg_wr_i.id == `AVR_PTR_X_LO || reg_wr_i.id == `AVR_PTR_X_LO + 1)));

endmodule

`default_nettype wire

// ==== tests/avr_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module avr_core_tb;

    typedef enum int {
        OP_LDI, OP_MOV,
        OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_AND, OP_EOR, OP_OR, OP_CP, OP_CPC,
        OP_CPI, OP_SUBI, OP_SBCI, OP_ORI, OP_ANDI,
        OP_COM, OP_NEG, OP_SWAP, OP_INC, OP_DEC, OP_ASR, OP_LSR, OP_ROR,
        OP_LD, OP_ST, OP_BRBS, OP_BRBC, OP_RJMP, OP_NOP
    } op_kind_e;

    localparam int PROG_LEN   = 200;
    localparam int FINAL_PC   = PROG_LEN - 1;
    localparam int MAX_CYCLES = 2000;

    logic        clock   = 1'b0;
    logic        reset_n = 1'b0;
    logic [15:0] ir_word;
    logic [7:0]  mem_rdata;
    logic [15:0] pc;
    logic [15:0] address;
    logic [7:0]  wdata;
    logic        we;
    logic        read;
    integer      seed = 32'h8583;

    // Program image, plus a description of each slot for the model
    logic [15:0] prog [0:255];
    op_kind_e    p_kind [0:255];
    int          p_a [0:255];       // Rd, or the flag bit of a branch
    int          p_b [0:255];       // Rr, K, pointer mode or offset
    int          prog_len;

    logic [7:0]  dmem [0:255];      // Memory seen by the bus
    logic [7:0]  m_mem [0:255];     // Model copy
    logic [7:0]  m_regs [0:31];
    logic [7:0]  m_sreg;
    int          m_pc;
    logic        exp_we;
    logic        exp_read;
    logic [15:0] exp_addr;
    logic [7:0]  exp_data;
    logic        ld_wait;
    int          ld_rd;

    always #20 clock = ~clock;

    assign ir_word   = prog[pc[7:0]];
    assign mem_rdata = dmem[address[7:0]];

    avr_core avr_core_inst (
        .clock     (clock),
        .reset_n   (reset_n),
        .ir_i      (ir_word),
        .data_i    (mem_rdata),
        .pc_o      (pc),
        .address_o (address),
        .data_o    (wdata),
        .we_o      (we),
        .read_o    (read)
    );

    // ------------------------------
    // Program generator
    // ------------------------------
    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic int pick_dest(input bit upper);
        int r;
        r = upper ? 16 + rand_below(16) : rand_below(32);
        if (r == 26 || r == 27)
            r = r - 2;              // Keep X out of reach
        return r;
    endfunction

    // Forward offset that cannot jump past the final loop
    function automatic int fwd_offset();
        int lim;
        lim = FINAL_PC - 1 - prog_len;
        if (lim > 3)
            lim = 3;
        return rand_below(lim + 1);
    endfunction

    task automatic emit(input op_kind_e kind, input int a, input int b);
        logic [7:0]  av;
        logic [7:0]  bv;
        logic [15:0] w;
        av = a[7:0];
        bv = b[7:0];
        case (kind)
            OP_LDI:  w = {4'hE, bv[7:4], av[3:0], bv[3:0]};
            OP_MOV:  w = {6'b001011, bv[4], av[4:0], bv[3:0]};
            OP_ADD:  w = {6'b000011, bv[4], av[4:0], bv[3:0]};
            OP_ADC:  w = {6'b000111, bv[4], av[4:0], bv[3:0]};
            OP_SUB:  w = {6'b000110, bv[4], av[4:0], bv[3:0]};
            OP_SBC:  w = {6'b000010, bv[4], av[4:0], bv[3:0]};
            OP_AND:  w = {6'b001000, bv[4], av[4:0], bv[3:0]};
            OP_EOR:  w = {6'b001001, bv[4], av[4:0], bv[3:0]};
            OP_OR:   w = {6'b001010, bv[4], av[4:0], bv[3:0]};
            OP_CP:   w = {6'b000101, bv[4], av[4:0], bv[3:0]};
            OP_CPC:  w = {6'b000001, bv[4], av[4:0], bv[3:0]};
            OP_CPI:  w = {4'h3, bv[7:4], av[3:0], bv[3:0]};
            OP_SBCI: w = {4'h4, bv[7:4], av[3:0], bv[3:0]};
            OP_SUBI: w = {4'h5, bv[7:4], av[3:0], bv[3:0]};
            OP_ORI:  w = {4'h6, bv[7:4], av[3:0], bv[3:0]};
            OP_ANDI: w = {4'h7, bv[7:4], av[3:0], bv[3:0]};
            OP_COM:  w = {7'b1001010, av[4:0], 4'h0};
            OP_NEG:  w = {7'b1001010, av[4:0], 4'h1};
            OP_SWAP: w = {7'b1001010, av[4:0], 4'h2};
            OP_INC:  w = {7'b1001010, av[4:0], 4'h3};
            OP_ASR:  w = {7'b1001010, av[4:0], 4'h5};
            OP_LSR:  w = {7'b1001010, av[4:0], 4'h6};
            OP_ROR:  w = {7'b1001010, av[4:0], 4'h7};
            OP_DEC:  w = {7'b1001010, av[4:0], 4'hA};
            OP_LD:   w = {7'b1001000, av[4:0], 2'b11, bv[1:0]};
            OP_ST:   w = {7'b1001001, av[4:0], 2'b11, bv[1:0]};
            OP_BRBS: w = {6'b111100, bv[6:0], av[2:0]};
            OP_BRBC: w = {6'b111101, bv[6:0], av[2:0]};
            OP_RJMP: w = {4'hC, b[11:0]};
            default: w = 16'h0000;
        endcase
        prog[prog_len]   = w;
        p_kind[prog_len] = kind;
        p_a[prog_len]    = a;
        p_b[prog_len]    = b;
        prog_len++;
    endtask

    task automatic gen_program();
        int pick;
        int rd;
        int src;
        int kval;
        int sub;
        int mode;
        int off;
        prog_len = 0;
        emit(OP_LDI, 26, rand_below(240));     // X below 0x00F0
        emit(OP_LDI, 27, 0);
        while (prog_len < FINAL_PC) begin
            pick = rand_below(10);
            src  = rand_below(32);
            kval = rand_below(256);
            sub  = rand_below(16);
            mode = rand_below(3);
            off  = fwd_offset();
            rd   = (pick == 0 || pick == 4) ? pick_dest(1'b1) : pick_dest(1'b0);
            case (pick)
                0:       emit(OP_LDI, rd, kval);
                1:       emit(OP_MOV, rd, src);
                2, 3:    emit(op_kind_e'(OP_ADD + sub % 9), rd, src);
                4:       emit(op_kind_e'(OP_CPI + sub % 5), rd, kval);
                5:       emit(op_kind_e'(OP_COM + sub % 8), rd, 0);
                6:       emit(OP_LD, rd, mode);
                7:       emit(OP_ST, rd, mode);
                8:       emit(sub[3] ? OP_BRBS : OP_BRBC, sub % 8, off);
                default: emit(OP_RJMP, 0, off);
            endcase
            // Expose a result through a store and a flag test
            if (pick <= 5 && prog_len < FINAL_PC - 2 && rand_below(3) == 0) begin
                emit(OP_ST, rd, rand_below(3));
                sub = rand_below(16);
                off = fwd_offset();
                emit(sub[3] ? OP_BRBS : OP_BRBC, sub % 8, off);
            end
        end
        emit(OP_RJMP, 0, -1);
    endtask

    // ------------------------------
    // Instruction model
    // ------------------------------
    // Returns {new sreg, result} from the AVR flag definitions
    function automatic logic [15:0] alu_model(input op_kind_e kind, input logic [7:0] d,
                                              input logic [7:0] r, input logic [7:0] s);
        logic [7:0] res;
        logic [7:0] ns;
        int         ci;
        int         full;
        int         half;
        int         sfull;
        ns  = s;
        ci  = 0;
        res = d;
        if (kind == OP_ADC || kind == OP_SBC || kind == OP_CPC || kind == OP_SBCI)
            ci = s[0];
        case (kind)
            OP_ADD, OP_ADC: begin
                full  = d + r + ci;
                half  = d[3:0] + r[3:0] + ci;
                sfull = $signed(d) + $signed(r) + ci;
                res   = full[7:0];
                ns[0] = full > 255;
                ns[5] = half > 15;
                ns[3] = sfull > 127 || sfull < -128;
            end
            OP_SUB, OP_CP, OP_SUBI, OP_CPI, OP_SBC, OP_CPC, OP_SBCI: begin
                full  = d - r - ci;
                half  = d[3:0] - r[3:0] - ci;
                sfull = $signed(d) - $signed(r) - ci;
                res   = full[7:0];
                ns[0] = full < 0;       // Borrow out of bit 7
                ns[5] = half < 0;
                ns[3] = sfull > 127 || sfull < -128;
            end
            OP_AND, OP_ANDI: begin
                res   = d & r;
                ns[3] = 1'b0;
            end
            OP_EOR: begin
                res   = d ^ r;
                ns[3] = 1'b0;
            end
            OP_OR, OP_ORI: begin
                res   = d | r;
                ns[3] = 1'b0;
            end
            OP_COM: begin
                res   = ~d;
                ns[3] = 1'b0;
                ns[0] = 1'b1;
            end
            OP_NEG: begin
                res   = 8'h00 - d;
                ns[5] = d[3:0] != 4'h0;
                ns[3] = d == 8'h80;
                ns[0] = d != 8'h00;
            end
            OP_SWAP: res = {d[3:0], d[7:4]};
            OP_INC: begin
                res   = d + 8'd1;
                ns[3] = d == 8'h7F;
            end
            OP_DEC: begin
                res   = d - 8'd1;
                ns[3] = d == 8'h80;
            end
            OP_ASR:  res = {d[7], d[7:1]};
            OP_LSR:  res = {1'b0, d[7:1]};
            OP_ROR:  res = {s[0], d[7:1]};
            default: ;
        endcase
        if (kind != OP_SWAP) begin
            ns[2] = res[7];
            ns[1] = (res == 8'h00);
            if (kind == OP_SBC || kind == OP_CPC || kind == OP_SBCI)
                ns[1] = ns[1] && s[1];
            if (kind == OP_ASR || kind == OP_LSR || kind == OP_ROR) begin
                ns[0] = d[0];
                ns[3] = ns[2] ^ ns[0];
            end
            ns[4] = ns[2] ^ ns[3];
        end
        return {ns, res};
    endfunction

    task automatic step_model();
        op_kind_e    kind;
        int          a;
        int          b;
        int          next_pc;
        logic [15:0] x;
        logic [15:0] res;
        logic [7:0]  operand;
        exp_we   = 1'b0;
        exp_read = 1'b0;
        if (ld_wait) begin              // Second cycle of LD
            m_regs[ld_rd] = m_mem[exp_addr[7:0]];
            ld_wait = 1'b0;
            m_pc++;
            return;
        end
        kind    = p_kind[m_pc];
        a       = p_a[m_pc];
        b       = p_b[m_pc];
        next_pc = m_pc + 1;
        x       = {m_regs[27], m_regs[26]};
        case (kind)
            OP_LDI: m_regs[a] = b[7:0];
            OP_MOV: m_regs[a] = m_regs[b];
            OP_LD, OP_ST: begin
                exp_addr = (b == 2) ? x - 16'd1 : x;
                if (b == 1)
                    x = x + 16'd1;
                else if (b == 2)
                    x = x - 16'd1;
                if (kind == OP_ST) begin
                    exp_we   = 1'b1;
                    exp_data = m_regs[a];
                    m_mem[exp_addr[7:0]] = m_regs[a];
                end else begin
                    exp_read = 1'b1;
                    ld_wait  = 1'b1;
                    ld_rd    = a;
                    next_pc  = m_pc;    // pc holds for the data cycle
                end
                {m_regs[27], m_regs[26]} = x;
            end
            OP_BRBS: if (m_sreg[a]) next_pc += b;
            OP_BRBC: if (!m_sreg[a]) next_pc += b;
            OP_RJMP: next_pc += b;
            OP_NOP:  ;
            default: begin
                operand = (kind >= OP_CPI && kind <= OP_ANDI) ? b[7:0] : m_regs[b];
                res     = alu_model(kind, m_regs[a], operand, m_sreg);
                m_sreg  = res[15:8];
                if (kind != OP_CP && kind != OP_CPC && kind != OP_CPI)
                    m_regs[a] = res[7:0];
            end
        endcase
        m_pc = next_pc;
    endtask

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_value(input string name, input logic [15:0] got,
                                input logic [15:0] want);
        stop_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, want));
    endtask

    task automatic check_cycle();
        assert (pc == m_pc[15:0])
            else report_value("pc_o", pc, m_pc[15:0]);
        assert (we == exp_we)
            else report_value("we_o", 16'(we), 16'(exp_we));
        assert (read == exp_read)
            else report_value("read_o", 16'(read), 16'(exp_read));
        if (exp_we || exp_read) begin
            assert (address == exp_addr)
                else report_value("address_o", address, exp_addr);
        end
        if (exp_we) begin
            assert (wdata == exp_data)
                else report_value("data_o", 16'(wdata), 16'(exp_data));
            dmem[address[7:0]] = wdata;     // Byte lands during the strobe
        end
    endtask

    initial begin
        int cycles;
        for (int i = 0; i < 256; i++) begin
            prog[i]   = 16'hCFFF;           // Unused slots trap in place
            p_kind[i] = OP_NOP;
            p_a[i]    = 0;
            p_b[i]    = 0;
            m_mem[i]  = 8'($random(seed));
            dmem[i]   = m_mem[i];
        end
        for (int i = 0; i < 32; i++)
            m_regs[i] = 8'h00;
        m_sreg   = 8'h00;
        m_pc     = 0;
        exp_we   = 1'b0;
        exp_read = 1'b0;
        exp_addr = 16'h0000;
        exp_data = 8'h00;
        ld_wait  = 1'b0;
        ld_rd    = 0;
        gen_program();

        repeat (16) @(posedge clock);
        reset_n <= 1'b1;

        // First pass sees the post-reset state with pc 0 and no strobes
        cycles = 0;
        while (m_pc != FINAL_PC) begin
            @(negedge clock);
            check_cycle();
            step_model();
            cycles++;
            if (cycles > MAX_CYCLES)
                stop_run("Timeout: the program never reached its final loop");
        end
        for (int i = 0; i < 4; i++) begin
            @(negedge clock);
            check_cycle();
            step_model();
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
